// File: rnm_pkg.sv
// rename window package: widths, sizes and head-segment state codes
package rnm_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // window geometry
   ////////////////////////////////////////////////////////////////////////////

   // total lines in the window
   localparam int NUM_LINES = 8;
   // lines per segment, two segments per window
   localparam int SEG_LINES = 4;
   // line index width
   localparam int LINE_BITS = 3;

   ////////////////////////////////////////////////////////////////////////////
   // register map layout
   ////////////////////////////////////////////////////////////////////////////

   // architectural registers tracked by the map
   localparam int NUM_LREG       = 4;
   localparam int LREG_BITS      = 2;
   localparam int PREG_BITS      = 4;
   // one entry is {ready, physical tag}
   localparam int MAP_ENTRY_BITS = PREG_BITS + 1;
   // entry k lives at bit offset k*MAP_ENTRY_BITS
   localparam int MAP_BITS       = NUM_LREG * MAP_ENTRY_BITS;

   // occupancy count must reach NUM_LINES
   localparam int CNT_BITS = 4;

   // head-segment FSM encodings, the state doubles as the arch flag
   localparam logic SEG0_HEAD = 1'b0;
   localparam logic SEG1_HEAD = 1'b1;

endpackage

// File: rnm_line.sv
// rename window line: stores one instruction and forwards its updated register map
`timescale 1ns/10ps

module rnm_line
   import rnm_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 wr_en_i,
   input  logic                 cmp_en_i,
   input  logic                 flush_i,
   input  logic [LREG_BITS-1:0] lsrc1_i,
   input  logic [LREG_BITS-1:0] lsrc2_i,
   input  logic [LREG_BITS-1:0] ldst_i,
   input  logic                 has_dst_i,
   input  logic [PREG_BITS-1:0] pdest_i,
   input  logic [MAP_BITS-1:0]  prv_map_i,
   output logic                 vld_o,
   output logic                 done_o,
   output logic [MAP_BITS-1:0]  cur_map_o,
   output logic [PREG_BITS-1:0] psrc1_o,
   output logic                 psrc1_rdy_o,
   output logic [PREG_BITS-1:0] psrc2_o,
   output logic                 psrc2_rdy_o,
   output logic [PREG_BITS-1:0] pdest_o,
   output logic [PREG_BITS-1:0] free_o
);

   // control state
   logic                 vld_q;
   logic                 rsv_q;
   // instruction payload
   logic [LREG_BITS-1:0] lsrc1_q;
   logic [LREG_BITS-1:0] lsrc2_q;
   logic [LREG_BITS-1:0] ldst_q;
   logic                 has_dst_q;
   logic [PREG_BITS-1:0] pdest_q;

   // a new write wins over flush and completion in the same cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         vld_q <= 1'b0;
         rsv_q <= 1'b0;
      end
      else if (wr_en_i)
      begin
         vld_q <= 1'b1;
         rsv_q <= 1'b0;
      end
      else if (flush_i)
      begin
         vld_q <= 1'b0;
         rsv_q <= 1'b0;
      end
      // completion only counts for a live line with a destination
      else if (cmp_en_i && vld_q && has_dst_q)
         rsv_q <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (wr_en_i)
      begin
         lsrc1_q   <= lsrc1_i;
         lsrc2_q   <= lsrc2_i;
         ldst_q    <= ldst_i;
         has_dst_q <= has_dst_i;
         pdest_q   <= pdest_i;
      end
   end

   // outgoing map, our destination overrides the incoming entry
   always_comb
   begin
      cur_map_o = prv_map_i;
      if (vld_q && has_dst_q)
         cur_map_o[ldst_q*MAP_ENTRY_BITS +: MAP_ENTRY_BITS] = {rsv_q, pdest_q};
   end

   // sources look up the map in force just before this line
   assign psrc1_o     = prv_map_i[lsrc1_q*MAP_ENTRY_BITS +: PREG_BITS];
   assign psrc1_rdy_o = prv_map_i[lsrc1_q*MAP_ENTRY_BITS + PREG_BITS];
   assign psrc2_o     = prv_map_i[lsrc2_q*MAP_ENTRY_BITS +: PREG_BITS];
   assign psrc2_rdy_o = prv_map_i[lsrc2_q*MAP_ENTRY_BITS + PREG_BITS];

   // old tag of ldst, released when this line retires
   assign free_o  = prv_map_i[ldst_q*MAP_ENTRY_BITS +: PREG_BITS];
   assign pdest_o = pdest_q;
   assign vld_o   = vld_q;
   // empty, no destination, or destination already resolved
   assign done_o  = !vld_q || !has_dst_q || rsv_q;

endmodule

// File: rnm_line_array.sv
// rename line matrix: map chain through all lines plus the two segment header maps
`timescale 1ns/10ps

module rnm_line_array
   import rnm_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           wr_en_i,
   input  logic [LINE_BITS-1:0]           wr_ptr_i,
   input  logic [LREG_BITS-1:0]           in_lsrc1_i,
   input  logic [LREG_BITS-1:0]           in_lsrc2_i,
   input  logic [LREG_BITS-1:0]           in_ldst_i,
   input  logic                           in_has_dst_i,
   input  logic [PREG_BITS-1:0]           in_pdest_i,
   input  logic                           cmp_valid_i,
   input  logic [LINE_BITS-1:0]           cmp_line_i,
   input  logic                           seg_switch_i,
   input  logic                           arch_i,
   output logic [NUM_LINES-1:0]           line_done_o,
   output logic [NUM_LINES-1:0]           line_vld_o,
   output logic [NUM_LINES*PREG_BITS-1:0] line_psrc1_o,
   output logic [NUM_LINES-1:0]           line_psrc1_rdy_o,
   output logic [NUM_LINES*PREG_BITS-1:0] line_psrc2_o,
   output logic [NUM_LINES-1:0]           line_psrc2_rdy_o,
   output logic [NUM_LINES*PREG_BITS-1:0] line_pdest_o,
   output logic [NUM_LINES*PREG_BITS-1:0] line_free_o
);

   logic [MAP_BITS-1:0] prv_map [NUM_LINES];
   logic [MAP_BITS-1:0] cur_map [NUM_LINES];
   // hdr0 feeds line 0, hdr1 feeds line SEG_LINES
   logic [MAP_BITS-1:0] hdr0_q;
   logic [MAP_BITS-1:0] hdr1_q;

   ////////////////////////////////////////////////////////////////////////////
   // segment headers
   ////////////////////////////////////////////////////////////////////////////

   // identity map out of reset, every tag ready
   // on a switch the header behind the retiring segment captures its end map
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int k = 0; k < NUM_LREG; k++)
         begin
            hdr0_q[k*MAP_ENTRY_BITS +: MAP_ENTRY_BITS] <= {1'b1, PREG_BITS'(k)};
            hdr1_q[k*MAP_ENTRY_BITS +: MAP_ENTRY_BITS] <= {1'b1, PREG_BITS'(k)};
         end
      end
      else if (seg_switch_i)
      begin
         if (arch_i)
            hdr0_q <= cur_map[NUM_LINES-1];
         else
            hdr1_q <= cur_map[SEG_LINES-1];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // line chain
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_LINES; i++)
   begin : g_line
      // head segment starts from its header, younger one follows the head's tail
      if (i == 0)
      begin : g_first
         assign prv_map[i] = arch_i ? cur_map[NUM_LINES-1] : hdr0_q;
      end
      else if (i == SEG_LINES)
      begin : g_mid
         assign prv_map[i] = arch_i ? hdr1_q : cur_map[SEG_LINES-1];
      end
      else
      begin : g_chain
         assign prv_map[i] = cur_map[i-1];
      end

      rnm_line u_line (
         .clk         (clk),
         .rst_n       (rst_n),
         .wr_en_i     (wr_en_i && (wr_ptr_i == LINE_BITS'(i))),
         .cmp_en_i    (cmp_valid_i && (cmp_line_i == LINE_BITS'(i))),
         // flush only the segment that is retiring now
         .flush_i     (seg_switch_i && (arch_i == (i >= SEG_LINES))),
         .lsrc1_i     (in_lsrc1_i),
         .lsrc2_i     (in_lsrc2_i),
         .ldst_i      (in_ldst_i),
         .has_dst_i   (in_has_dst_i),
         .pdest_i     (in_pdest_i),
         .prv_map_i   (prv_map[i]),
         .vld_o       (line_vld_o[i]),
         .done_o      (line_done_o[i]),
         .cur_map_o   (cur_map[i]),
         .psrc1_o     (line_psrc1_o[i*PREG_BITS +: PREG_BITS]),
         .psrc1_rdy_o (line_psrc1_rdy_o[i]),
         .psrc2_o     (line_psrc2_o[i*PREG_BITS +: PREG_BITS]),
         .psrc2_rdy_o (line_psrc2_rdy_o[i]),
         .pdest_o     (line_pdest_o[i*PREG_BITS +: PREG_BITS]),
         .free_o      (line_free_o[i*PREG_BITS +: PREG_BITS])
      );
   end

endmodule

// File: rnm_slot_cnt.sv
// rename window allocator: write pointer, occupancy count and input ready
`timescale 1ns/10ps

module rnm_slot_cnt
   import rnm_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 in_valid_i,
   input  logic                 seg_switch_i,
   output logic                 in_ready_o,
   output logic                 wr_en_o,
   output logic [LINE_BITS-1:0] wr_ptr_o,
   output logic [CNT_BITS-1:0]  count_o
);

   logic [CNT_BITS-1:0] cnt_nxt;

   // room while the window is not full
   assign in_ready_o = (count_o != CNT_BITS'(NUM_LINES));
   // accept pulse
   assign wr_en_o    = in_valid_i && in_ready_o;

   // a switch frees a whole segment, an accept takes one line
   always_comb
   begin
      cnt_nxt = count_o;
      if (seg_switch_i)
         cnt_nxt = cnt_nxt - CNT_BITS'(SEG_LINES);
      if (wr_en_o)
         cnt_nxt = cnt_nxt + 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr_o <= '0;
         count_o  <= '0;
      end
      else
      begin
         count_o <= cnt_nxt;
         // circular pointer over the whole window
         if (wr_en_o)
            wr_ptr_o <= (wr_ptr_o == LINE_BITS'(NUM_LINES-1)) ? '0 : wr_ptr_o + 1'b1;
      end
   end

endmodule

// File: rnm_seg_ctrl.sv
// head-segment FSM: retires the head segment once it is full and resolved
`timescale 1ns/10ps

module rnm_seg_ctrl
   import rnm_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [CNT_BITS-1:0]  count_i,
   input  logic [NUM_LINES-1:0] line_done_i,
   output logic                 seg_switch_o,
   output logic                 arch_o
);

   logic state_q;
   logic state_nxt;
   logic head_done;

   // done bits of whichever segment is the head
   always_comb
   begin
      case (state_q)
         SEG0_HEAD: head_done = &line_done_i[SEG_LINES-1:0];
         default:   head_done = &line_done_i[NUM_LINES-1:SEG_LINES];
      endcase
   end

   // head segment full means count has passed its last line
   assign seg_switch_o = (count_i >= CNT_BITS'(SEG_LINES)) && head_done;

   ////////////////////////////////////////////////////////////////////////////
   // state transitions
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         SEG0_HEAD:
         begin
            if (seg_switch_o)
               state_nxt = SEG1_HEAD;
         end
         default:
         begin
            if (seg_switch_o)
               state_nxt = SEG0_HEAD;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= SEG0_HEAD;
      else
         state_q <= state_nxt;
   end

   // arch high while segment 1 is the head
   assign arch_o = (state_q == SEG1_HEAD);

endmodule

// File: rnm_out_select.sv
// rename read port: maps a priority slot onto a physical line and muxes its result
`timescale 1ns/10ps

module rnm_out_select
   import rnm_pkg::*;
(
   input  logic [LINE_BITS-1:0]           rd_slot_i,
   input  logic                           arch_i,
   input  logic [NUM_LINES-1:0]           line_vld_i,
   input  logic [NUM_LINES*PREG_BITS-1:0] line_psrc1_i,
   input  logic [NUM_LINES-1:0]           line_psrc1_rdy_i,
   input  logic [NUM_LINES*PREG_BITS-1:0] line_psrc2_i,
   input  logic [NUM_LINES-1:0]           line_psrc2_rdy_i,
   input  logic [NUM_LINES*PREG_BITS-1:0] line_pdest_i,
   input  logic [NUM_LINES*PREG_BITS-1:0] line_free_i,
   output logic                           rd_vld_o,
   output logic [PREG_BITS-1:0]           rd_psrc1_o,
   output logic                           rd_psrc1_rdy_o,
   output logic [PREG_BITS-1:0]           rd_psrc2_o,
   output logic                           rd_psrc2_rdy_o,
   output logic [PREG_BITS-1:0]           rd_pdest_o,
   output logic [PREG_BITS-1:0]           rd_free_o
);

   logic [LINE_BITS-1:0] line_sel;

   // slot 0 is the oldest head line, so rotate by a segment when seg 1 leads
   assign line_sel = arch_i ? LINE_BITS'((rd_slot_i + SEG_LINES) % NUM_LINES) : rd_slot_i;

   assign rd_vld_o       = line_vld_i[line_sel];
   assign rd_psrc1_o     = line_psrc1_i[line_sel*PREG_BITS +: PREG_BITS];
   assign rd_psrc1_rdy_o = line_psrc1_rdy_i[line_sel];
   assign rd_psrc2_o     = line_psrc2_i[line_sel*PREG_BITS +: PREG_BITS];
   assign rd_psrc2_rdy_o = line_psrc2_rdy_i[line_sel];
   assign rd_pdest_o     = line_pdest_i[line_sel*PREG_BITS +: PREG_BITS];
   assign rd_free_o      = line_free_i[line_sel*PREG_BITS +: PREG_BITS];

endmodule

// File: rnm_top.sv
// rename window top: allocator, segment FSM, line matrix and priority read port
`timescale 1ns/10ps

module rnm_top
   import rnm_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   // instruction input
   input  logic                 in_valid_i,
   input  logic [LREG_BITS-1:0] in_lsrc1_i,
   input  logic [LREG_BITS-1:0] in_lsrc2_i,
   input  logic [LREG_BITS-1:0] in_ldst_i,
   input  logic                 in_has_dst_i,
   input  logic [PREG_BITS-1:0] in_pdest_i,
   output logic                 in_ready_o,
   output logic [LINE_BITS-1:0] in_line_o,
   // completion
   input  logic                 cmp_valid_i,
   input  logic [LINE_BITS-1:0] cmp_line_i,
   // priority read port
   input  logic [LINE_BITS-1:0] rd_slot_i,
   output logic                 rd_vld_o,
   output logic [PREG_BITS-1:0] rd_psrc1_o,
   output logic                 rd_psrc1_rdy_o,
   output logic [PREG_BITS-1:0] rd_psrc2_o,
   output logic                 rd_psrc2_rdy_o,
   output logic [PREG_BITS-1:0] rd_pdest_o,
   output logic [PREG_BITS-1:0] rd_free_o,
   // status
   output logic                 arch_o
);

   logic                           wr_en;
   logic [LINE_BITS-1:0]           wr_ptr;
   logic [CNT_BITS-1:0]            count;
   logic                           seg_switch;
   logic                           arch;
   logic [NUM_LINES-1:0]           line_done;
   // flat per-line results, line i at [i*PREG_BITS +: PREG_BITS]
   logic [NUM_LINES-1:0]           line_vld;
   logic [NUM_LINES*PREG_BITS-1:0] line_psrc1;
   logic [NUM_LINES-1:0]           line_psrc1_rdy;
   logic [NUM_LINES*PREG_BITS-1:0] line_psrc2;
   logic [NUM_LINES-1:0]           line_psrc2_rdy;
   logic [NUM_LINES*PREG_BITS-1:0] line_pdest;
   logic [NUM_LINES*PREG_BITS-1:0] line_free;

   // the sender sees which line it is about to take
   assign in_line_o = wr_ptr;
   assign arch_o    = arch;

   rnm_slot_cnt u_slot_cnt (
      .clk          (clk),
      .rst_n        (rst_n),
      .in_valid_i   (in_valid_i),
      .seg_switch_i (seg_switch),
      .in_ready_o   (in_ready_o),
      .wr_en_o      (wr_en),
      .wr_ptr_o     (wr_ptr),
      .count_o      (count)
   );

   rnm_seg_ctrl u_seg_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .count_i      (count),
      .line_done_i  (line_done),
      .seg_switch_o (seg_switch),
      .arch_o       (arch)
   );

   rnm_line_array u_line_array (
      .clk              (clk),
      .rst_n            (rst_n),
      .wr_en_i          (wr_en),
      .wr_ptr_i         (wr_ptr),
      .in_lsrc1_i       (in_lsrc1_i),
      .in_lsrc2_i       (in_lsrc2_i),
      .in_ldst_i        (in_ldst_i),
      .in_has_dst_i     (in_has_dst_i),
      .in_pdest_i       (in_pdest_i),
      .cmp_valid_i      (cmp_valid_i),
      .cmp_line_i       (cmp_line_i),
      .seg_switch_i     (seg_switch),
      .arch_i           (arch),
      .line_done_o      (line_done),
      .line_vld_o       (line_vld),
      .line_psrc1_o     (line_psrc1),
      .line_psrc1_rdy_o (line_psrc1_rdy),
      .line_psrc2_o     (line_psrc2),
      .line_psrc2_rdy_o (line_psrc2_rdy),
      .line_pdest_o     (line_pdest),
      .line_free_o      (line_free)
   );

   rnm_out_select u_out_select (
      .rd_slot_i        (rd_slot_i),
      .arch_i           (arch),
      .line_vld_i       (line_vld),
      .line_psrc1_i     (line_psrc1),
      .line_psrc1_rdy_i (line_psrc1_rdy),
      .line_psrc2_i     (line_psrc2),
      .line_psrc2_rdy_i (line_psrc2_rdy),
      .line_pdest_i     (line_pdest),
      .line_free_i      (line_free),
      .rd_vld_o         (rd_vld_o),
      .rd_psrc1_o       (rd_psrc1_o),
      .rd_psrc1_rdy_o   (rd_psrc1_rdy_o),
      .rd_psrc2_o       (rd_psrc2_o),
      .rd_psrc2_rdy_o   (rd_psrc2_rdy_o),
      .rd_pdest_o       (rd_pdest_o),
      .rd_free_o        (rd_free_o)
   );

endmodule

// File: rnm_clk_gen.sv
// rename window testbench clock and reset source, 10 ns period
`timescale 1ns/10ps

module rnm_clk_gen
(
   output logic clk,
   output logic rst_n
);

   // free-running clock, 5 ns per phase
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // hold reset for ten rising edges, release on a falling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: rnm_assert.sv
// rename window assertions on the input handshake, write pointer and head switch
`timescale 1ns/10ps

module rnm_assert
   import rnm_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic                 in_valid_i,
   input logic                 in_ready_i,
   input logic [LINE_BITS-1:0] in_line_i,
   input logic                 wr_en_i,
   input logic                 arch_i
);

   // number of failed assertions
   int err_cnt = 0;

   // the line pointer holds unless a request is accepted with room in the window
   a_accept_ready : assert property (@(posedge clk) disable iff (!rst_n)
      !(in_valid_i && in_ready_i) |=> $stable(in_line_i))
      else
      begin
         $error("in_line_o moved without an accepted request");
         err_cnt++;
      end

   // pointer steps by one line per accepted instruction and wraps at the end
   a_line_step : assert property (@(posedge clk) disable iff (!rst_n)
      wr_en_i |=> (in_line_i == LINE_BITS'(($past(in_line_i) + 1) % NUM_LINES)))
      else
      begin
         $error("in_line_o did not advance by one after an accept");
         err_cnt++;
      end

   // a head switch frees a segment so the window has room right after it
   a_switch_room : assert property (@(posedge clk) disable iff (!rst_n)
      $changed(arch_i) |-> in_ready_i)
      else
      begin
         $error("arch_o toggled without in_ready_o high");
         err_cnt++;
      end

endmodule

bind rnm_top rnm_assert u_rnm_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .in_valid_i (in_valid_i),
   .in_ready_i (in_ready_o),
   .in_line_i  (in_line_o),
   .wr_en_i    (wr_en),
   .arch_i     (arch_o)
);

// File: rnm_tb.sv
// rename window testbench that replays the cases file against the DUT and checks its outputs
`timescale 1ns/10ps

module rnm_tb
   import rnm_pkg::*;
();

   localparam int RST_CYCLES = 10;

   logic                 clk;
   logic                 rst_n;
   logic                 in_valid;
   logic [LREG_BITS-1:0] in_lsrc1;
   logic [LREG_BITS-1:0] in_lsrc2;
   logic [LREG_BITS-1:0] in_ldst;
   logic                 in_has_dst;
   logic [PREG_BITS-1:0] in_pdest;
   logic                 in_ready;
   logic [LINE_BITS-1:0] in_line;
   logic                 cmp_valid;
   logic [LINE_BITS-1:0] cmp_line;
   logic [LINE_BITS-1:0] rd_slot;
   logic                 rd_vld;
   logic [PREG_BITS-1:0] rd_psrc1;
   logic                 rd_psrc1_rdy;
   logic [PREG_BITS-1:0] rd_psrc2;
   logic                 rd_psrc2_rdy;
   logic [PREG_BITS-1:0] rd_pdest;
   logic [PREG_BITS-1:0] rd_free;
   logic                 arch;
   // line the instruction in flight is expected to take
   logic [LINE_BITS-1:0] exp_line;
   int                   cycle_cnt   = 0;
   int                   cycle_limit = 0;

   rnm_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   rnm_top u_rnm_top (
      .clk            (clk),
      .rst_n          (rst_n),
      .in_valid_i     (in_valid),
      .in_lsrc1_i     (in_lsrc1),
      .in_lsrc2_i     (in_lsrc2),
      .in_ldst_i      (in_ldst),
      .in_has_dst_i   (in_has_dst),
      .in_pdest_i     (in_pdest),
      .in_ready_o     (in_ready),
      .in_line_o      (in_line),
      .cmp_valid_i    (cmp_valid),
      .cmp_line_i     (cmp_line),
      .rd_slot_i      (rd_slot),
      .rd_vld_o       (rd_vld),
      .rd_psrc1_o     (rd_psrc1),
      .rd_psrc1_rdy_o (rd_psrc1_rdy),
      .rd_psrc2_o     (rd_psrc2),
      .rd_psrc2_rdy_o (rd_psrc2_rdy),
      .rd_pdest_o     (rd_pdest),
      .rd_free_o      (rd_free),
      .arch_o         (arch)
   );

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_preg(input string name, input logic [PREG_BITS-1:0] act,
                             input logic [PREG_BITS-1:0] exp);
      if (act !== exp)
         abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, act, exp));
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp)
         abort_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, name, act, exp));
   endtask

   task automatic check_line(input string name, input logic [LINE_BITS-1:0] act,
                             input logic [LINE_BITS-1:0] exp);
      if (act !== exp)
         abort_run($sformatf("error at %0d ns: %s is %0d, expected %0d", $time, name, act, exp));
   endtask

   // advance one clock and check the line of an accept at the coming rising edge
   task automatic tick();
      logic accept;
      accept = in_valid && in_ready;
      if (accept)
         check_line("in_line_o", in_line, exp_line);
      @(negedge clk);
      if (accept)
         in_valid = 1'b0;
      // completion is a single-cycle pulse
      cmp_valid = 1'b0;
   endtask

   // run limit grows with the length of the cases file
   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
         abort_run($sformatf("timeout: test did not finish within %0d cycles", cycle_limit));
      else if (u_rnm_top.u_rnm_assert.err_cnt != 0)
         abort_run("assertion failure reported by the bound checker");
   end

   ////////////////////////////////////////////////////////////////////////////
   // command loop
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int    fd;
      int    code;
      int    cmd;
      int    n_lines;
      int    arg [8];
      string line_buf;
      in_valid   = 1'b0;
      in_lsrc1   = '0;
      in_lsrc2   = '0;
      in_ldst    = '0;
      in_has_dst = 1'b0;
      in_pdest   = '0;
      cmp_valid  = 1'b0;
      cmp_line   = '0;
      rd_slot    = '0;
      exp_line   = '0;
      n_lines    = 0;
      fd = $fopen("rnm_cases.txt", "r");
      if (fd == 0)
         abort_run("cannot open rnm_cases.txt for reading");
      // first pass only sizes the timeout
      while (!$feof(fd))
      begin
         code = $fgets(line_buf, fd);
         if (code > 0)
            n_lines++;
      end
      $fclose(fd);
      cycle_limit = 4 * n_lines + RST_CYCLES;
      fd = $fopen("rnm_cases.txt", "r");
      @(posedge rst_n);
      while ($fscanf(fd, " %c", cmd) == 1)
      begin
         case (cmd)
            "#": code = $fgets(line_buf, fd);
            "W":
            begin
               code = $fscanf(fd, "%d %d %d %d %d %d", arg[0], arg[1], arg[2], arg[3],
                              arg[4], arg[5]);
               // only one instruction in flight so a held one blocks the next
               while (in_valid)
                  tick();
               in_lsrc1   = LREG_BITS'(arg[0]);
               in_lsrc2   = LREG_BITS'(arg[1]);
               in_ldst    = LREG_BITS'(arg[2]);
               in_has_dst = arg[3][0];
               in_pdest   = PREG_BITS'(arg[4]);
               exp_line   = LINE_BITS'(arg[5]);
               in_valid   = 1'b1;
               tick();
            end
            "C":
            begin
               code = $fscanf(fd, "%d", arg[0]);
               cmp_line  = LINE_BITS'(arg[0]);
               cmp_valid = 1'b1;
               tick();
            end
            "R":
            begin
               code = $fscanf(fd, "%d %d %d %d %d %d %d %d", arg[0], arg[1], arg[2], arg[3],
                              arg[4], arg[5], arg[6], arg[7]);
               rd_slot = LINE_BITS'(arg[0]);
               tick();
               check_bit("rd_vld_o", rd_vld, arg[1][0]);
               check_preg("rd_psrc1_o", rd_psrc1, PREG_BITS'(arg[2]));
               check_bit("rd_psrc1_rdy_o", rd_psrc1_rdy, arg[3][0]);
               check_preg("rd_psrc2_o", rd_psrc2, PREG_BITS'(arg[4]));
               check_bit("rd_psrc2_rdy_o", rd_psrc2_rdy, arg[5][0]);
               check_preg("rd_pdest_o", rd_pdest, PREG_BITS'(arg[6]));
               check_preg("rd_free_o", rd_free, PREG_BITS'(arg[7]));
            end
            "F": check_bit("in_ready_o", in_ready, 1'b0);
            "A":
            begin
               code = $fscanf(fd, "%d", arg[0]);
               check_bit("arch_o", arch, arg[0][0]);
            end
            "N":
            begin
               code = $fscanf(fd, "%d", arg[0]);
               repeat (arg[0]) tick();
            end
            default: abort_run($sformatf("unknown command '%c' in rnm_cases.txt", cmd));
         endcase
      end
      $fclose(fd);
      // let a held instruction drain before the verdict
      while (in_valid)
         tick();
      if (u_rnm_top.u_rnm_assert.err_cnt != 0)
         abort_run("assertion failure reported by the bound checker");
      else
      begin
         $display("Everything OK");
         $finish;
      end
   end

endmodule

// File: rnm_cases.txt
# W lsrc1 lsrc2 ldst has_dst pdest line | C line | N cycles | F (ready low) | A arch
# R slot vld psrc1 psrc1_rdy psrc2 psrc2_rdy pdest free
A 0
W 1 2 3 1 8 0
R 0 1 1 1 2 1 8 3
W 3 0 1 1 9 1
W 1 3 2 1 10 2
R 1 1 8 0 0 1 9 1
R 2 1 9 0 8 0 10 2
C 0
R 1 1 8 1 0 1 9 1
R 2 1 9 0 8 1 10 2
W 2 1 3 1 11 3
W 0 3 0 1 12 4
W 1 1 1 1 13 5
W 2 0 2 1 14 6
W 3 2 0 1 15 7
R 3 1 10 0 9 0 11 8
R 7 1 11 0 14 0 15 12
F
W 3 1 2 1 3 0
N 2
F
C 1
C 2
C 3
N 1
A 1
R 0 1 0 1 11 1 12 0
R 4 1 11 1 13 0 3 14

// File: build.f
rnm_pkg.sv
rnm_line.sv
rnm_line_array.sv
rnm_slot_cnt.sv
rnm_seg_ctrl.sv
rnm_out_select.sv
rnm_top.sv
rnm_clk_gen.sv
rnm_assert.sv
rnm_tb.sv

// File: Bender.yml
package:
  name: rnm_window

sources:
  - rnm_pkg.sv
  - rnm_line.sv
  - rnm_line_array.sv
  - rnm_slot_cnt.sv
  - rnm_seg_ctrl.sv
  - rnm_out_select.sv
  - rnm_top.sv
  - target: simulation
    files:
      - rnm_clk_gen.sv
      - rnm_assert.sv
      - rnm_tb.sv
